// ==== testbench/ooo_core_input.txt ====
// Columns: kind[23:20] (1 instr, 2 flush, 3 expect), rd[19:16], data[15:0]
// data is the instruction word for kind 1 and the committed value for kind 3
10C805 // LDI r1, 5
310005
10D003 // LDI r2, 3
320003
101940 // ADD r3, r1, r2
330008
106320 // SUB r4, r3, r1
340003
101B80 // ADD r3, r3, r4
33000B
10E8FF // LDI r5, 0xFF
3500FF
10B5A0 // MUL r6, r5, r5
36FE01
100940 // ADD r1, r1, r2
310008
101240 // ADD r2, r2, r2
320006
102480 // ADD r4, r4, r4
340006
10BEA0 // MUL r7, r6, r5
3702FF
108920 // MUL r1, r1, r1, flushed
200000
101940 // ADD r3, r1, r2
33000E
109360 // MUL r2, r3, r3
3200C4
106DE0 // SUB r5, r5, r7
35FE00
103360 // ADD r6, r3, r3
36001C
1002A0 // ADD r0, r2, r5
30FEC4

// ==== ooo_core.f ====
+incdir+design
design/isa_pkg.sv
design/rob_pkg.sv
design/instr_decoder.sv
design/exec_unit.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/ooo_core_top.sv
testbench/ooo_core_properties.sv
testbench/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ooo_core testbench with Verilator and run it.
# Exit status is zero only when the pass line appears in the output.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module ooo_core_tb -f ooo_core.f --Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vooo_core_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== testbench/ooo_core_tb.sv ====
// Testbench for the out-of-order core. Streams instructions and flushes from
// the input file and checks every commit against the expected records in it.
module ooo_core_tb import isa_pkg::*; ();

  // Record kinds in the top nibble of each input word
  localparam logic [3:0] REC_INSTR  = 4'h1;
  localparam logic [3:0] REC_FLUSH  = 4'h2;
  localparam logic [3:0] REC_EXPECT = 4'h3;
  localparam int         MAX_RECS   = 64;
  localparam int         CYCLES_PER_REC = 40;

  logic     clk_i;
  logic     rst_ni;
  logic     flush;
  logic     instr_valid;
  logic     instr_ready;
  instr_t   instr;
  logic     commit_valid;
  logic     commit_ready;
  reg_idx_t commit_rd;
  word_t    commit_value;

  logic [23:0] recs [MAX_RECS];
  int          num_recs;
  int          exp_total;
  reg_idx_t    exp_rd_q  [$];
  word_t       exp_val_q [$];
  int          cycle_cnt;
  int          cycle_limit;
  integer      seed;

  ooo_core_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush),
    .instr_valid_i  (instr_valid),
    .instr_ready_o  (instr_ready),
    .instr_i        (instr),
    .commit_valid_o (commit_valid),
    .commit_ready_i (commit_ready),
    .commit_rd_o    (commit_rd),
    .commit_value_o (commit_value)
  );

  always #2 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // Valid holds until ready is sampled high at a falling edge
  // The transfer itself happens on the next rising edge
  task automatic send_instr(input instr_t word);
    instr_valid = 1'b1;
    instr       = word;
    @(negedge clk_i);
    while (!instr_ready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    instr_valid = 1'b0;
    instr       = '0;
  endtask

  // Flush high for the cycle right after the last accept
  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk_i);
    #1;
    flush = 1'b0;
  endtask

  // Older work must be committed before a flush request
  task automatic wait_for_drain(input int target);
    while (exp_total - exp_rd_q.size() < target) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_commit();
    reg_idx_t exp_rd;
    word_t    exp_val;
    assert (exp_rd_q.size() != 0) else begin
      $display("Unexpected commit of r%0d after all expected commits were seen",
               commit_rd);
      stop_on_error();
    end
    exp_rd  = exp_rd_q.pop_front();
    exp_val = exp_val_q.pop_front();
    assert (commit_rd == exp_rd && commit_value == exp_val) else begin
      $display("FAILED at time %0t: commit r%0d = %h, expected r%0d = %h",
               $time, commit_rd, commit_value, exp_rd, exp_val);
      stop_on_error();
    end
  endtask

  // --------------------------------------------------------------------------
  // Commit side
  // --------------------------------------------------------------------------
  // Random back-pressure with ready in about 5 of 8 cycles
  always @(posedge clk_i) begin : p_commit_ready
    #1;
    commit_ready = ({$random(seed)} % 8) < 5;
  end

  // Transfer is decided here and happens on the next rising edge
  always @(negedge clk_i) begin : p_commit_check
    if (rst_ni && commit_valid && commit_ready) begin
      check_commit();
    end
  end

  always @(posedge clk_i) begin : p_timeout
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d commits still outstanding",
               cycle_cnt, exp_rd_q.size());
      stop_on_error();
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : p_drive
    logic [23:0] rec;
    int          expects_before;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    flush        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    commit_ready = 1'b1;
    cycle_cnt    = 0;
    cycle_limit  = 0;
    seed         = 98;
    foreach (recs[i]) recs[i] = '0;
    $readmemh("testbench/ooo_core_input.txt", recs);
    // Kind zero ends the record list
    num_recs = 0;
    while (num_recs < MAX_RECS && recs[num_recs][23:20] != 4'h0) begin
      if (recs[num_recs][23:20] == REC_EXPECT) begin
        exp_rd_q.push_back(recs[num_recs][18:16]);
        exp_val_q.push_back(recs[num_recs][15:0]);
      end
      num_recs++;
    end
    exp_total   = exp_rd_q.size();
    assert (exp_total > 0) else begin
      $display("No expected commits were found in the input file");
      stop_on_error();
    end
    cycle_limit = CYCLES_PER_REC * num_recs;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    expects_before = 0;
    for (int idx = 0; idx < num_recs; idx++) begin
      rec = recs[idx];
      case (rec[23:20])
        REC_INSTR: begin
          if (idx + 1 < num_recs && recs[idx+1][23:20] == REC_FLUSH) begin
            wait_for_drain(expects_before);
          end
          send_instr(rec[15:0]);
        end
        REC_FLUSH:  pulse_flush();
        REC_EXPECT: expects_before++;
        default: begin
          $display("Unknown record kind %h at input line %0d", rec[23:20], idx);
          stop_on_error();
        end
      endcase
    end
    while (exp_rd_q.size() != 0) @(posedge clk_i);
    // Idle stretch catches duplicated commits
    repeat (20) @(posedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== testbench/ooo_core_properties.sv ====
// Concurrent handshake checks for the core top level.
// Bound into every ooo_core_top instance by the bind at the end.
module ooo_core_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic instr_valid_i,
  input logic instr_ready_i,
  input logic commit_valid_i,
  input logic commit_ready_i
);

  // Instruction source holds valid until accepted
  instr_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && !instr_ready_i |=> instr_valid_i)
    else $error("instruction valid dropped before transfer");

  // Commit stays offered under back-pressure unless a flush empties the ROB
  commit_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i && !commit_ready_i && !flush_i |=> commit_valid_i)
    else $error("commit valid dropped before transfer");

  // Flush empties the ROB in one cycle
  flush_clears_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !commit_valid_i)
    else $error("commit valid high in the cycle after flush");

  // Ready out of reset
  ready_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> instr_ready_i)
    else $error("instruction ready low during reset");

endmodule

bind ooo_core_top ooo_core_properties u_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .instr_valid_i  (instr_valid_i),
  .instr_ready_i  (instr_ready_o),
  .commit_valid_i (commit_valid_o),
  .commit_ready_i (commit_ready_i)
);

// ==== design/ooo_core_top.sv ====
// Top of the out-of-order core. Connects decode, execute, reorder buffer
// and register file; instructions in, in-order commits out.
`include "ooo_core_macros.svh"

module ooo_core_top import isa_pkg::*, rob_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // Instruction port
  input  logic     instr_valid_i,
  output logic     instr_ready_o,
  input  instr_t   instr_i,
  // Commit port
  output logic     commit_valid_o,
  input  logic     commit_ready_i,
  output reg_idx_t commit_rd_o,
  output word_t    commit_value_o
);

  // Issue path
  logic     issue_valid;
  lane_e    issue_lane;
  opcode_e  issue_op;
  word_t    issue_a;
  word_t    issue_b;
  reg_idx_t issue_rd;
  rob_idx_t issue_tag;
  logic     rob_ready;
  rob_idx_t tail_idx;
  logic     exec_ready;
  // Register file lookup
  reg_idx_t rf_rs1;
  reg_idx_t rf_rs2;
  word_t    rf_val1;
  word_t    rf_val2;
  logic     rf_busy1;
  logic     rf_busy2;
  rob_idx_t rf_tag1;
  rob_idx_t rf_tag2;
  // ROB forwarding
  rob_idx_t fwd_tag1;
  rob_idx_t fwd_tag2;
  logic     fwd_ready1;
  logic     fwd_ready2;
  word_t    fwd_val1;
  word_t    fwd_val2;
  // CDB
  logic     cdb_valid;
  rob_idx_t cdb_tag;
  word_t    cdb_value;
  // Commit to register file
  rob_idx_t commit_tag;
  logic     commit_fire;

  assign commit_fire = commit_valid_o && commit_ready_i;

  instr_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .rf_rs1_o      (rf_rs1),
    .rf_rs2_o      (rf_rs2),
    .rf_val1_i     (rf_val1),
    .rf_val2_i     (rf_val2),
    .rf_busy1_i    (rf_busy1),
    .rf_busy2_i    (rf_busy2),
    .rf_tag1_i     (rf_tag1),
    .rf_tag2_i     (rf_tag2),
    .fwd_tag1_o    (fwd_tag1),
    .fwd_tag2_o    (fwd_tag2),
    .fwd_ready1_i  (fwd_ready1),
    .fwd_ready2_i  (fwd_ready2),
    .fwd_val1_i    (fwd_val1),
    .fwd_val2_i    (fwd_val2),
    .rob_ready_i   (rob_ready),
    .tail_idx_i    (tail_idx),
    .exec_ready_i  (exec_ready),
    .issue_valid_o (issue_valid),
    .issue_lane_o  (issue_lane),
    .issue_op_o    (issue_op),
    .issue_a_o     (issue_a),
    .issue_b_o     (issue_b),
    .issue_rd_o    (issue_rd),
    .issue_tag_o   (issue_tag)
  );

  exec_unit u_exec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid),
    .issue_lane_i  (issue_lane),
    .issue_op_i    (issue_op),
    .issue_a_i     (issue_a),
    .issue_b_i     (issue_b),
    .issue_tag_i   (issue_tag),
    .exec_ready_o  (exec_ready),
    .cdb_valid_o   (cdb_valid),
    .cdb_tag_o     (cdb_tag),
    .cdb_value_o   (cdb_value)
  );

  reorder_buffer u_rob (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .alloc_i        (issue_valid),
    .alloc_rd_i     (issue_rd),
    .rob_ready_o    (rob_ready),
    .tail_idx_o     (tail_idx),
    .cdb_valid_i    (cdb_valid),
    .cdb_tag_i      (cdb_tag),
    .cdb_value_i    (cdb_value),
    .fwd_tag1_i     (fwd_tag1),
    .fwd_tag2_i     (fwd_tag2),
    .fwd_ready1_o   (fwd_ready1),
    .fwd_ready2_o   (fwd_ready2),
    .fwd_val1_o     (fwd_val1),
    .fwd_val2_o     (fwd_val2),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_rd_o    (commit_rd_o),
    .commit_value_o (commit_value_o),
    .commit_tag_o   (commit_tag)
  );

  // Rename on issue, write back on commit
  arch_regfile u_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .rs1_i        (rf_rs1),
    .rs2_i        (rf_rs2),
    .val1_o       (rf_val1),
    .val2_o       (rf_val2),
    .busy1_o      (rf_busy1),
    .busy2_o      (rf_busy2),
    .tag1_o       (rf_tag1),
    .tag2_o       (rf_tag2),
    .rename_en_i  (issue_valid),
    .rename_rd_i  (issue_rd),
    .rename_tag_i (issue_tag),
    .wr_en_i      (commit_fire),
    .wr_rd_i      (commit_rd_o),
    .wr_value_i   (commit_value_o),
    .wr_tag_i     (commit_tag)
  );

endmodule

// ==== design/arch_regfile.sv ====
// Architectural register file with a rename tag per register. Written at
// commit; busy marks a register whose newest value is still in the ROB.
`include "ooo_core_macros.svh"

module arch_regfile import isa_pkg::*, rob_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // Operand read
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    val1_o,
  output word_t    val2_o,
  output logic     busy1_o,
  output logic     busy2_o,
  output rob_idx_t tag1_o,
  output rob_idx_t tag2_o,
  // Rename at issue
  input  logic     rename_en_i,
  input  reg_idx_t rename_rd_i,
  input  rob_idx_t rename_tag_i,
  // Write at commit
  input  logic     wr_en_i,
  input  reg_idx_t wr_rd_i,
  input  word_t    wr_value_i,
  input  rob_idx_t wr_tag_i
);

  word_t    regs_q [`OOO_NREGS];
  logic     busy_q [`OOO_NREGS];
  rob_idx_t tag_q  [`OOO_NREGS];

  // Committed values survive a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      foreach (regs_q[i]) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_rd_i] <= wr_value_i;
    end
  end

  // ------------------------------------------------------------------------
  // Rename tags
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rename
    if (!rst_ni) begin
      foreach (busy_q[i]) begin
        busy_q[i] <= 1'b0;
        tag_q[i]  <= '0;
      end
    end else if (flush_i) begin
      foreach (busy_q[i]) begin
        busy_q[i] <= 1'b0;
      end
    end else begin
      foreach (busy_q[i]) begin
        // New rename wins over a commit to the same register
        if (rename_en_i && rename_rd_i == reg_idx_t'(i)) begin
          busy_q[i] <= 1'b1;
          tag_q[i]  <= rename_tag_i;
        end else if (wr_en_i && wr_rd_i == reg_idx_t'(i) && tag_q[i] == wr_tag_i) begin
          // Only the newest producer frees the register
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  assign val1_o  = regs_q[rs1_i];
  assign val2_o  = regs_q[rs2_i];
  assign busy1_o = busy_q[rs1_i];
  assign busy2_o = busy_q[rs2_i];
  assign tag1_o  = tag_q[rs1_i];
  assign tag2_o  = tag_q[rs2_i];

endmodule

// ==== design/reorder_buffer.sv ====
// Circular reorder buffer. Allocates at issue, captures CDB results,
// forwards ready values to decode and commits in program order.
`include "ooo_core_macros.svh"

module reorder_buffer import isa_pkg::*, rob_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // Allocation from issue
  input  logic     alloc_i,
  input  reg_idx_t alloc_rd_i,
  output logic     rob_ready_o,
  output rob_idx_t tail_idx_o,
  // Common data bus, always accepted
  input  logic     cdb_valid_i,
  input  rob_idx_t cdb_tag_i,
  input  word_t    cdb_value_i,
  // Operand forwarding
  input  rob_idx_t fwd_tag1_i,
  input  rob_idx_t fwd_tag2_i,
  output logic     fwd_ready1_o,
  output logic     fwd_ready2_o,
  output word_t    fwd_val1_o,
  output word_t    fwd_val2_o,
  // Commit
  output logic     commit_valid_o,
  input  logic     commit_ready_i,
  output reg_idx_t commit_rd_o,
  output word_t    commit_value_o,
  output rob_idx_t commit_tag_o
);

  // Entry state
  logic     ent_valid_q [`OOO_ROB_DEPTH];
  logic     ent_done_q  [`OOO_ROB_DEPTH];
  reg_idx_t ent_rd_q    [`OOO_ROB_DEPTH];
  word_t    ent_value_q [`OOO_ROB_DEPTH];

  // Pointers wrap naturally, depth is a power of two
  rob_idx_t head_q;
  rob_idx_t tail_q;
  logic     pop;

  assign pop = commit_valid_o && commit_ready_i;

  // --------------------------------------------------------------------------
  // Entry update
  // --------------------------------------------------------------------------
  // Priority per entry: allocate, then pop, then CDB write
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_entry_ctrl
    if (!rst_ni) begin
      foreach (ent_valid_q[i]) begin
        ent_valid_q[i] <= 1'b0;
        ent_done_q[i]  <= 1'b0;
      end
    end else if (flush_i) begin
      // Clearing valid empties the buffer
      foreach (ent_valid_q[i]) begin
        ent_valid_q[i] <= 1'b0;
      end
    end else begin
      foreach (ent_valid_q[i]) begin
        if (alloc_i && tail_q == rob_idx_t'(i)) begin
          ent_valid_q[i] <= 1'b1;
          ent_done_q[i]  <= 1'b0;
        end else if (pop && head_q == rob_idx_t'(i)) begin
          ent_valid_q[i] <= 1'b0;
        end else if (cdb_valid_i && cdb_tag_i == rob_idx_t'(i)) begin
          ent_done_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_entry_data
    foreach (ent_rd_q[i]) begin
      if (alloc_i && tail_q == rob_idx_t'(i)) begin
        ent_rd_q[i] <= alloc_rd_i;
      end else if (cdb_valid_i && cdb_tag_i == rob_idx_t'(i)) begin
        ent_value_q[i] <= cdb_value_i;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Head and tail
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pointers
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
    end else if (flush_i) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (alloc_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  // Full when the tail slot is still occupied
  assign rob_ready_o = !ent_valid_q[tail_q];
  assign tail_idx_o  = tail_q;

  // Decode only asks for tags of busy registers, which point at live entries
  assign fwd_ready1_o = ent_done_q[fwd_tag1_i];
  assign fwd_ready2_o = ent_done_q[fwd_tag2_i];
  assign fwd_val1_o   = ent_value_q[fwd_tag1_i];
  assign fwd_val2_o   = ent_value_q[fwd_tag2_i];

  // Oldest entry leaves once its result is in
  assign commit_valid_o = ent_valid_q[head_q] && ent_done_q[head_q];
  assign commit_rd_o    = ent_rd_q[head_q];
  assign commit_value_o = ent_value_q[head_q];
  assign commit_tag_o   = head_q;

endmodule

// ==== design/exec_unit.sv ====
// Execute block. One-cycle ALU lane and a pipelined multiplier share the
// CDB; the multiplier wins and a losing ALU result waits in a skid register.
`include "ooo_core_macros.svh"

module exec_unit import isa_pkg::*, rob_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // Issue
  input  logic     issue_valid_i,
  input  lane_e    issue_lane_i,
  input  opcode_e  issue_op_i,
  input  word_t    issue_a_i,
  input  word_t    issue_b_i,
  input  rob_idx_t issue_tag_i,
  output logic     exec_ready_o,
  // Common data bus
  output logic     cdb_valid_o,
  output rob_idx_t cdb_tag_o,
  output word_t    cdb_value_o
);

  logic     alu_fire;
  logic     mul_fire;
  word_t    alu_res_d;
  // ALU stage
  logic     alu_valid_q;
  rob_idx_t alu_tag_q;
  word_t    alu_res_q;
  // Multiplier pipeline, last stage drives the CDB
  logic     mul_valid_q [`OOO_MUL_LAT];
  rob_idx_t mul_tag_q   [`OOO_MUL_LAT];
  word_t    mul_res_q   [`OOO_MUL_LAT];
  // Skid for ALU results that lost the CDB
  logic     skid_valid_q;
  rob_idx_t skid_tag_q;
  word_t    skid_res_q;
  // Arbitration
  logic     mul_out_valid;
  logic     alu_cand_valid;
  rob_idx_t alu_cand_tag;
  word_t    alu_cand_res;
  logic     collide;

  assign alu_fire = issue_valid_i && (issue_lane_i == LANE_ALU);
  assign mul_fire = issue_valid_i && (issue_lane_i == LANE_MUL);

  // --------------------------------------------------------------------------
  // ALU lane
  // --------------------------------------------------------------------------
  always_comb begin : p_alu
    case (issue_op_i)
      OP_ADD:  alu_res_d = issue_a_i + issue_b_i;
      OP_SUB:  alu_res_d = issue_a_i - issue_b_i;
      // LDI passes its immediate through
      default: alu_res_d = issue_a_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_alu_valid
    if (!rst_ni) begin
      alu_valid_q <= 1'b0;
    end else if (flush_i) begin
      alu_valid_q <= 1'b0;
    end else begin
      alu_valid_q <= alu_fire;
    end
  end

  always_ff @(posedge clk_i) begin : p_alu_data
    if (alu_fire) begin
      alu_tag_q <= issue_tag_i;
      alu_res_q <= alu_res_d;
    end
  end

  // --------------------------------------------------------------------------
  // Multiplier lane
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mul_valid
    if (!rst_ni) begin
      foreach (mul_valid_q[i]) begin
        mul_valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      // Drop everything in flight
      foreach (mul_valid_q[i]) begin
        mul_valid_q[i] <= 1'b0;
      end
    end else begin
      mul_valid_q[0] <= mul_fire;
      for (int i = 1; i < `OOO_MUL_LAT; i++) begin
        mul_valid_q[i] <= mul_valid_q[i-1];
      end
    end
  end

  // Low XLEN bits of the product, then carried down the pipe
  always_ff @(posedge clk_i) begin : p_mul_data
    mul_tag_q[0] <= issue_tag_i;
    mul_res_q[0] <= issue_a_i * issue_b_i;
    for (int i = 1; i < `OOO_MUL_LAT; i++) begin
      mul_tag_q[i] <= mul_tag_q[i-1];
      mul_res_q[i] <= mul_res_q[i-1];
    end
  end

  // --------------------------------------------------------------------------
  // CDB arbitration
  // --------------------------------------------------------------------------
  assign mul_out_valid = mul_valid_q[`OOO_MUL_LAT-1];

  // Skid and ALU stage are never both full, issue is held meanwhile
  assign alu_cand_valid = skid_valid_q || alu_valid_q;
  assign alu_cand_tag   = skid_valid_q ? skid_tag_q : alu_tag_q;
  assign alu_cand_res   = skid_valid_q ? skid_res_q : alu_res_q;

  // Multiplier has priority
  assign collide      = alu_cand_valid && mul_out_valid;
  assign exec_ready_o = !collide;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_skid_valid
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (flush_i) begin
      skid_valid_q <= 1'b0;
    end else begin
      skid_valid_q <= collide;
    end
  end

  always_ff @(posedge clk_i) begin : p_skid_data
    if (collide) begin
      skid_tag_q <= alu_cand_tag;
      skid_res_q <= alu_cand_res;
    end
  end

  assign cdb_valid_o = mul_out_valid || alu_cand_valid;
  assign cdb_tag_o   = mul_out_valid ? mul_tag_q[`OOO_MUL_LAT-1] : alu_cand_tag;
  assign cdb_value_o = mul_out_valid ? mul_res_q[`OOO_MUL_LAT-1] : alu_cand_res;

endmodule

// ==== design/instr_decoder.sv ====
// Decode and issue stage. Splits the instruction, picks operands from the
// register file or ROB, stalls on hazards and issues in the accept cycle.
`include "ooo_core_macros.svh"

module instr_decoder import isa_pkg::*, rob_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  // Instruction stream
  input  logic     instr_valid_i,
  output logic     instr_ready_o,
  input  instr_t   instr_i,
  // Register file lookup
  output reg_idx_t rf_rs1_o,
  output reg_idx_t rf_rs2_o,
  input  word_t    rf_val1_i,
  input  word_t    rf_val2_i,
  input  logic     rf_busy1_i,
  input  logic     rf_busy2_i,
  input  rob_idx_t rf_tag1_i,
  input  rob_idx_t rf_tag2_i,
  // ROB forwarding
  output rob_idx_t fwd_tag1_o,
  output rob_idx_t fwd_tag2_o,
  input  logic     fwd_ready1_i,
  input  logic     fwd_ready2_i,
  input  word_t    fwd_val1_i,
  input  word_t    fwd_val2_i,
  // Downstream status
  input  logic     rob_ready_i,
  input  rob_idx_t tail_idx_i,
  input  logic     exec_ready_i,
  // Issue
  output logic     issue_valid_o,
  output lane_e    issue_lane_o,
  output opcode_e  issue_op_o,
  output word_t    issue_a_o,
  output word_t    issue_b_o,
  output reg_idx_t issue_rd_o,
  output rob_idx_t issue_tag_o
);

  opcode_e opcode;
  word_t   imm;
  logic    uses_src;
  logic    stall1;
  logic    stall2;
  logic    flush_q;

  // --------------------------------------------------------------------------
  // Field split
  // --------------------------------------------------------------------------
  assign opcode   = opcode_e'(instr_i[15:14]);
  assign rf_rs1_o = instr_i[10:8];
  assign rf_rs2_o = instr_i[7:5];
  // Zero-extended LDI immediate
  assign imm      = {{(`OOO_XLEN-8){1'b0}}, instr_i[7:0]};
  // LDI overlaps rs fields with the immediate, so no sources
  assign uses_src = (opcode != OP_LDI);

  // --------------------------------------------------------------------------
  // Operand resolve
  // --------------------------------------------------------------------------
  // Busy register means value lives in ROB entry named by its tag
  assign fwd_tag1_o = rf_tag1_i;
  assign fwd_tag2_o = rf_tag2_i;

  // Producer issued but result not yet written back
  assign stall1 = uses_src && rf_busy1_i && !fwd_ready1_i;
  assign stall2 = uses_src && rf_busy2_i && !fwd_ready2_i;

  assign issue_a_o = !uses_src  ? imm :
                     rf_busy1_i ? fwd_val1_i : rf_val1_i;
  assign issue_b_o = rf_busy2_i ? fwd_val2_i : rf_val2_i;

  // Quiet cycle after a flush while ROB and rename state restart
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_flush_q
    if (!rst_ni) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= flush_i;
    end
  end

  // --------------------------------------------------------------------------
  // Issue
  // --------------------------------------------------------------------------
  assign instr_ready_o = rob_ready_i && exec_ready_i && !stall1 && !stall2 &&
                         !flush_i && !flush_q;
  assign issue_valid_o = instr_valid_i && instr_ready_o;

  assign issue_lane_o = (opcode == OP_MUL) ? LANE_MUL : LANE_ALU;
  assign issue_op_o   = opcode;
  assign issue_rd_o   = instr_i[13:11];
  // New entry goes at the ROB tail
  assign issue_tag_o  = tail_idx_i;

endmodule

// ==== design/rob_pkg.sv ====
// Reorder-buffer types: entry index used as rename tag, and the
// execute lane select carried with each issued instruction.
`include "ooo_core_macros.svh"

package rob_pkg;

  // ROB entry index, also the rename tag
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

  // Execute lane select
  typedef enum logic {
    LANE_ALU = 1'b0,
    LANE_MUL = 1'b1
  } lane_e;

endpackage

// ==== design/isa_pkg.sv ====
// Instruction-set types for the core: data word, register index,
// instruction word and opcode encoding.
`include "ooo_core_macros.svh"

package isa_pkg;

  // Data word
  typedef logic [`OOO_XLEN-1:0] word_t;

  // Architectural register index
  typedef logic [$clog2(`OOO_NREGS)-1:0] reg_idx_t;

  // Raw instruction
  // [15:14] opcode, [13:11] rd, [10:8] rs1, [7:5] rs2
  // LDI takes an unsigned immediate from [7:0]
  typedef logic [15:0] instr_t;

  // Opcodes
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_LDI = 2'b11
  } opcode_e;

endpackage

// ==== design/ooo_core_macros.svh ====
// Width and depth constants shared by the out-of-order core.
// Include in any file that sizes data, registers, ROB or multiplier.
`ifndef OOO_CORE_MACROS_SVH
`define OOO_CORE_MACROS_SVH

// Data word width
`define OOO_XLEN 16

// Architectural registers
`define OOO_NREGS 8

// Reorder buffer entries, power of two
`define OOO_ROB_DEPTH 4

// Multiplier pipeline stages
`define OOO_MUL_LAT 4

`endif
